// File: design/synth_pkg.sv
package synth_pkg;

  // voice count and index width
  localparam int num_banks = 6;
  localparam int bank_idx_w = 5;

  // audio path widths
  localparam int period_w = 23;
  localparam int sample_w = 24;
  localparam int amp_w = 16;
  localparam int len_w = 8;

  // done stream word and fifo sizing
  localparam int done_w = 8;
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = 3;

  // host note command, period zero means note off
  typedef struct packed {
    logic [3:0]            spare;
    logic [bank_idx_w-1:0] bank;
    logic [period_w-1:0]   period;
  } note_cmd_t;

  // one bit per voice
  typedef logic [num_banks-1:0] bank_mask_t;

endpackage

// File: design/axil_pkg.sv
package axil_pkg;

  // byte address width of the register window
  localparam int axil_addr_w = 4;

  // register map
  localparam logic [axil_addr_w-1:0] cfg_addr = 4'h0;
  localparam logic [axil_addr_w-1:0] status_addr = 4'h4;

  // only response ever returned
  localparam logic [1:0] resp_okay = 2'b00;

  // flag bit positions inside the flags byte
  localparam int enable_bit = 0;

  // field layout of the voice config word
  typedef struct packed {
    logic [7:0]  flags;
    logic [7:0]  note_length;
    logic [15:0] amplitude;
  } cfg_fields_t;

  // byte lanes for strobed writes, fields for the decoder
  typedef union packed {
    logic [3:0][7:0] bytes;
    cfg_fields_t     fields;
  } cfg_word_u;

endpackage

// File: design/note_bus_if.sv
`timescale 1ns/1ps

interface note_bus_if;
  import synth_pkg::*;

  // one-cycle strobes, one bit per bank
  bank_mask_t on_mask;
  bank_mask_t off_mask;

  // note settings, valid in the on_mask cycle
  logic [period_w-1:0] period;
  logic [amp_w-1:0]    amplitude;
  logic [len_w-1:0]    note_length;

  // decoder side
  modport src (
    output on_mask, off_mask, period, amplitude, note_length
  );

  // tone bank side
  modport dst (
    input on_mask, off_mask, period, amplitude, note_length
  );

endinterface

// File: design/synth_regs.sv
`timescale 1ns/1ps

module synth_regs (
  input  logic                            clk_calc,
  input  logic                            rst_n,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [axil_pkg::axil_addr_w-1:0] awaddr,
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [31:0]                     wdata,
  input  logic [3:0]                      wstrb,
  output logic                            bvalid,
  input  logic                            bready,
  output logic [1:0]                      bresp,
  input  logic                            arvalid,
  output logic                            arready,
  input  logic [axil_pkg::axil_addr_w-1:0] araddr,
  output logic                            rvalid,
  input  logic                            rready,
  output logic [31:0]                     rdata,
  output logic [1:0]                      rresp,
  input  logic                            overflow,
  input  synth_pkg::bank_mask_t           active,
  output axil_pkg::cfg_word_u             cfg
);
  import axil_pkg::*;

  logic        wr_hs;
  logic        rd_hs;
  logic        ovf_sticky;
  logic        ovf_clr;
  logic [31:0] status_word;
  logic [31:0] rd_mux;

  // ready pulses only while both channels hold valid
  assign wr_hs = awready && awvalid && wvalid;
  assign rd_hs = arready && arvalid;

  // write 1 to bit 0 of status clears overflow
  assign ovf_clr = wr_hs && (awaddr == status_addr) && wstrb[0] && wdata[0];

  // overflow in bit 0, playing banks from bit 8
  assign status_word = (32'(active) << 8) | 32'(ovf_sticky);

  assign bresp = resp_okay;
  assign rresp = resp_okay;

  // write channel, one transaction in flight
  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      awready    <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      cfg        <= '0;
      ovf_sticky <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !bvalid && !awready;
      wready  <= awvalid && wvalid && !bvalid && !awready;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      // strobed bytes land through the byte view
      if (wr_hs && (awaddr == cfg_addr)) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            cfg.bytes[b] <= wdata[8*b +: 8];
          end
        end
      end
      // a new overflow beats a clear in the same cycle
      if (overflow) begin
        ovf_sticky <= 1'b1;
      end else if (ovf_clr) begin
        ovf_sticky <= 1'b0;
      end
    end
  end

  // read address decode, unmapped reads zero
  always_comb begin
    case (araddr)
      cfg_addr:    rd_mux = cfg;
      status_addr: rd_mux = status_word;
      default:     rd_mux = '0;
    endcase
  end

  // read channel control
  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // read data held until rready
  always_ff @(posedge clk_calc) begin
    if (rd_hs) begin
      rdata <= rd_mux;
    end
  end

endmodule

// File: design/note_decoder.sv
`timescale 1ns/1ps

module note_decoder (
  input  logic                 clk_calc,
  input  logic                 rst_n,
  input  logic                 note_valid,
  input  synth_pkg::note_cmd_t note_word,
  output logic                 note_ready,
  input  axil_pkg::cfg_word_u  cfg,
  note_bus_if.src              bus
);
  import synth_pkg::*;
  import axil_pkg::*;

  logic       take;
  logic       bank_ok;
  bank_mask_t sel;
  bank_mask_t on_q;
  bank_mask_t off_q;

  // no back-pressure once out of reset
  assign take    = note_valid && note_ready;
  assign bank_ok = note_word.bank < bank_idx_w'(num_banks);
  assign sel     = bank_mask_t'(1) << note_word.bank;

  // strobes last exactly one cycle
  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      note_ready <= 1'b0;
      on_q       <= '0;
      off_q      <= '0;
    end else begin
      note_ready <= 1'b1;
      on_q       <= '0;
      off_q      <= '0;
      if (take && bank_ok) begin
        if (note_word.period == '0) begin
          off_q <= sel;
        end else if (cfg.fields.flags[enable_bit]) begin
          on_q <= sel;
        end
      end
    end
  end

  // settings ride along with the strobe
  always_ff @(posedge clk_calc) begin
    if (take) begin
      bus.period      <= note_word.period;
      bus.amplitude   <= cfg.fields.amplitude;
      bus.note_length <= cfg.fields.note_length;
    end
  end

  assign bus.on_mask  = on_q;
  assign bus.off_mask = off_q;

endmodule

// File: design/tone_bank.sv
`timescale 1ns/1ps

module tone_bank #(
  parameter int bank_sel = 0
) (
  input  logic                                clk_calc,
  input  logic                                rst_n,
  note_bus_if.dst                             bus,
  output logic signed [synth_pkg::sample_w-1:0] tone,
  output logic                                playing,
  output logic                                done
);
  import synth_pkg::*;

  logic [period_w-1:0]        period_q;
  logic [period_w-1:0]        phase_cnt;
  logic [amp_w-1:0]           amp_q;
  logic [len_w-1:0]           len_q;
  logic [len_w-1:0]           len_cnt;
  logic                       phase;
  logic                       phase_end;
  logic signed [sample_w-1:0] amp_ext;

  assign phase_end = phase_cnt == (period_q - 1'b1);
  assign amp_ext   = $signed({{(sample_w-amp_w){1'b0}}, amp_q});

  // high phase +amp, low phase -amp, silent zero
  assign tone = !playing ? '0 : (phase ? amp_ext : -amp_ext);

  // latched note settings
  always_ff @(posedge clk_calc) begin
    if (bus.on_mask[bank_sel]) begin
      period_q <= bus.period;
      amp_q    <= bus.amplitude;
      len_q    <= bus.note_length;
    end
  end

  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      playing   <= 1'b0;
      done      <= 1'b0;
      phase     <= 1'b0;
      phase_cnt <= '0;
      len_cnt   <= '0;
    end else begin
      done <= 1'b0;
      if (bus.on_mask[bank_sel]) begin
        // restart from the top of the high phase
        playing   <= 1'b1;
        phase     <= 1'b1;
        phase_cnt <= '0;
        len_cnt   <= '0;
      end else if (bus.off_mask[bank_sel]) begin
        playing <= 1'b0;
      end else if (playing) begin
        if (phase_end) begin
          phase_cnt <= '0;
          phase     <= ~phase;
          // end of low phase closes one full cycle
          if (!phase) begin
            len_cnt <= len_cnt + 1'b1;
            if (len_q != '0 && len_cnt == len_q - 1'b1) begin
              playing <= 1'b0;
              done    <= 1'b1;
            end
          end
        end else begin
          phase_cnt <= phase_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: design/voice_mixer.sv
`timescale 1ns/1ps

module voice_mixer (
  input  logic                                 clk_calc,
  input  logic                                 rst_n,
  input  logic signed [synth_pkg::sample_w-1:0] tones [synth_pkg::num_banks],
  input  synth_pkg::bank_mask_t                playing,
  input  synth_pkg::bank_mask_t                dones,
  output logic signed [synth_pkg::sample_w-1:0] audio,
  output synth_pkg::bank_mask_t                active,
  output logic                                 done_event,
  output logic [synth_pkg::bank_idx_w-1:0]     done_idx
);
  import synth_pkg::*;

  logic signed [sample_w-1:0] sum;
  logic                       hit;
  logic [bank_idx_w-1:0]      hit_idx;

  // six full-scale voices still fit in 24 bits
  always_comb begin
    sum = '0;
    for (int i = 0; i < num_banks; i++) begin
      sum = sum + tones[i];
    end
  end

  // last match wins, so the highest finishing bank is reported
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < num_banks; i++) begin
      if (dones[i]) begin
        hit     = 1'b1;
        hit_idx = bank_idx_w'(i);
      end
    end
  end

  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      audio      <= '0;
      active     <= '0;
      done_event <= 1'b0;
      done_idx   <= '0;
    end else begin
      audio      <= sum;
      active     <= playing;
      done_event <= hit;
      done_idx   <= hit_idx;
    end
  end

endmodule

// File: design/done_fifo.sv
`timescale 1ns/1ps

module done_fifo (
  input  logic                             clk_calc,
  input  logic                             rst_n,
  input  logic                             done_event,
  input  logic [synth_pkg::bank_idx_w-1:0] done_idx,
  output logic                             done_valid,
  output logic [synth_pkg::done_w-1:0]     done_bank,
  input  logic                             done_ready,
  output logic                             overflow
);
  import synth_pkg::*;

  logic [bank_idx_w-1:0] mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full       = count == (fifo_ptr_w + 1)'(fifo_depth);
  // events arriving while full are lost
  assign push       = done_event && !full;
  assign pop        = done_valid && done_ready;
  assign done_valid = count != '0;
  // head entry, zero-extended onto the stream
  assign done_bank  = {{(done_w-bank_idx_w){1'b0}}, mem[rd_ptr]};

  always_ff @(posedge clk_calc) begin
    if (push) begin
      mem[wr_ptr] <= done_idx;
    end
  end

  // pointers wrap naturally at depth 8
  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= done_event && full;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
    end
  end

endmodule

// File: design/synth_top.sv
`timescale 1ns/1ps

module synth_top (
  input  logic                                 clk_calc,
  input  logic                                 rst_n,
  input  logic                                 note_valid,
  output logic                                 note_ready,
  input  logic [31:0]                          note_word,
  output logic                                 done_valid,
  input  logic                                 done_ready,
  output logic [synth_pkg::done_w-1:0]         done_bank,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [axil_pkg::axil_addr_w-1:0]     awaddr,
  input  logic                                 wvalid,
  output logic                                 wready,
  input  logic [31:0]                          wdata,
  input  logic [3:0]                           wstrb,
  output logic                                 bvalid,
  input  logic                                 bready,
  output logic [1:0]                           bresp,
  input  logic                                 arvalid,
  output logic                                 arready,
  input  logic [axil_pkg::axil_addr_w-1:0]     araddr,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic [31:0]                          rdata,
  output logic [1:0]                           rresp,
  output logic signed [synth_pkg::sample_w-1:0] audio
);
  import synth_pkg::*;
  import axil_pkg::*;

  cfg_word_u                  cfg;
  bank_mask_t                 active;
  bank_mask_t                 playing;
  bank_mask_t                 dones;
  logic signed [sample_w-1:0] tones [num_banks];
  logic                       overflow;
  logic                       done_event;
  logic [bank_idx_w-1:0]      done_idx;

  // decoder to banks
  note_bus_if nbus ();

  synth_regs u_regs (
    .clk_calc, .rst_n,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .overflow, .active, .cfg
  );

  note_decoder u_dec (
    .clk_calc, .rst_n,
    .note_valid, .note_word, .note_ready,
    .cfg, .bus(nbus.src)
  );

  // one voice per bank index
  for (genvar g = 0; g < num_banks; g++) begin : g_bank
    tone_bank #(.bank_sel(g)) u_bank (
      .clk_calc, .rst_n,
      .bus(nbus.dst),
      .tone(tones[g]),
      .playing(playing[g]),
      .done(dones[g])
    );
  end

  voice_mixer u_mix (
    .clk_calc, .rst_n,
    .tones, .playing, .dones,
    .audio, .active, .done_event, .done_idx
  );

  done_fifo u_fifo (
    .clk_calc, .rst_n,
    .done_event, .done_idx,
    .done_valid, .done_bank, .done_ready,
    .overflow
  );

endmodule

// File: tests/synth_sva.sv
`timescale 1ns/1ps

module synth_sva (
  input logic                         clk_calc,
  input logic                         rst_n,
  input logic                         bvalid,
  input logic                         bready,
  input logic                         rvalid,
  input logic                         rready,
  input logic [31:0]                  rdata,
  input logic                         done_valid,
  input logic                         done_ready,
  input logic [synth_pkg::done_w-1:0] done_bank
);

  // write response held until taken
  a_bvalid_hold: assert property (@(posedge clk_calc) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // read data frozen while stalled
  a_rvalid_hold: assert property (@(posedge clk_calc) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // head of the done fifo stays put under back-pressure
  a_done_hold: assert property (@(posedge clk_calc) disable iff (!rst_n)
    done_valid && !done_ready |=> done_valid && $stable(done_bank))
    else $error("done_valid or done_bank changed before done_ready");

endmodule

bind synth_top synth_sva u_sva (
  .clk_calc(clk_calc), .rst_n(rst_n),
  .bvalid(bvalid), .bready(bready),
  .rvalid(rvalid), .rready(rready), .rdata(rdata),
  .done_valid(done_valid), .done_ready(done_ready), .done_bank(done_bank)
);

// File: tests/synth_tb.sv
`timescale 1ns/1ps

module synth_tb;

  // wait loop limit in clock cycles
  localparam int wait_limit = 300;
  // zero samples in a row that count as silence
  localparam int quiet_len = 16;

  logic               clk_calc;
  logic               rst_n;
  logic               note_valid;
  logic               note_ready;
  logic [31:0]        note_word;
  logic               done_valid;
  logic               done_ready;
  logic [7:0]         done_bank;
  logic               awvalid;
  logic               awready;
  logic [3:0]         awaddr;
  logic               wvalid;
  logic               wready;
  logic [31:0]        wdata;
  logic [3:0]         wstrb;
  logic               bvalid;
  logic               bready;
  logic [1:0]         bresp;
  logic               arvalid;
  logic               arready;
  logic [3:0]         araddr;
  logic               rvalid;
  logic               rready;
  logic [31:0]        rdata;
  logic [1:0]         rresp;
  logic signed [23:0] audio;

  logic [31:0] rng;

  synth_top dut0 (.*);

  // 100 ns period
  always #50 clk_calc = ~clk_calc;

  // report and stop the run
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // xorshift32 step
  function automatic logic [31:0] xorshift_next(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // all tasks start and end on a falling edge
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    n = 0;
    while (!(awready && wready)) begin
      @(negedge clk_calc);
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for awready and wready");
    end
    // handshake lands on the next rising edge
    @(negedge clk_calc);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid) begin
      @(negedge clk_calc);
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for bvalid");
    end
    assert (bresp == 2'b00)
      else stop_on_error($sformatf("FAILED bresp: got %h expected %h", bresp, 2'b00));
    // response left pending for a few random cycles
    rng = xorshift_next(rng);
    repeat (rng[1:0]) @(negedge clk_calc);
    bready = 1'b1;
    @(negedge clk_calc);
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, input logic [31:0] expected);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    n = 0;
    while (!arready) begin
      @(negedge clk_calc);
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for arready");
    end
    @(negedge clk_calc);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      @(negedge clk_calc);
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for rvalid");
    end
    assert (rdata == expected)
      else stop_on_error($sformatf("FAILED rdata: got %h expected %h at address %h",
                                   rdata, expected, addr));
    assert (rresp == 2'b00)
      else stop_on_error($sformatf("FAILED rresp: got %h expected %h", rresp, 2'b00));
    // read data left pending for a few random cycles
    rng = xorshift_next(rng);
    repeat (rng[1:0]) @(negedge clk_calc);
    rready = 1'b1;
    @(negedge clk_calc);
    rready = 1'b0;
  endtask

  // one word on the note stream
  task automatic send_note(input logic [31:0] word);
    int n;
    note_word  = word;
    note_valid = 1'b1;
    n = 0;
    while (!note_ready) begin
      @(negedge clk_calc);
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for note_ready");
    end
    @(negedge clk_calc);
    note_valid = 1'b0;
  endtask

  // random done_ready stalls until one index transfers
  task automatic expect_done(input logic [7:0] bank);
    int   n;
    logic got;
    n   = 0;
    got = 1'b0;
    while (!got) begin
      rng = xorshift_next(rng);
      done_ready = rng[1:0] != 2'b00;
      if (done_valid && done_ready) begin
        assert (done_bank == bank)
          else stop_on_error($sformatf("FAILED done_bank: got %h expected %h",
                                       done_bank, bank));
        got = 1'b1;
      end
      @(negedge clk_calc);
      n++;
      if (!got && n > wait_limit) stop_on_error("timeout waiting for a done index");
    end
    done_ready = 1'b0;
  endtask

  // audio must start at +mag and then stay on the allowed levels
  task automatic check_tone(input logic signed [23:0] mag, input int cycles,
                            input logic allow_zero);
    int   n;
    logic seen_neg;
    n = 0;
    while (audio != mag) begin
      @(negedge clk_calc);
      n++;
      if (n > wait_limit) stop_on_error("audio never reached the expected amplitude");
    end
    seen_neg = 1'b0;
    repeat (cycles) begin
      assert (audio == mag || audio == -mag || (allow_zero && audio == '0))
        else stop_on_error($sformatf("FAILED audio: got %h expected %h or %h",
                                     audio, mag, -mag));
      if (audio == -mag) seen_neg = 1'b1;
      @(negedge clk_calc);
    end
    assert (seen_neg)
      else stop_on_error("audio never swung to the negative amplitude");
  endtask

  // silence must begin within limit cycles and then hold
  task automatic wait_silence(input int limit);
    int n;
    int run;
    n   = 0;
    run = 0;
    while (run < quiet_len) begin
      if (audio == '0) run++;
      else run = 0;
      if (run < quiet_len && n >= limit + quiet_len - 1) begin
        stop_on_error($sformatf("audio did not stay silent, last value %h", audio));
      end
      @(negedge clk_calc);
      n++;
    end
  endtask

  // done stream must stay empty
  task automatic check_no_done(input int cycles);
    repeat (cycles) begin
      assert (!done_valid)
        else stop_on_error("done_valid went high although no note should finish");
      @(negedge clk_calc);
    end
  endtask

  initial begin
    int          fd;
    int          rc;
    string       line;
    string       op;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    clk_calc   = 1'b0;
    rst_n      = 1'b0;
    note_valid = 1'b0;
    note_word  = '0;
    done_ready = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    rng        = 32'h6cdfdb56;
    // reset for 5 cycles and release on a falling edge
    repeat (5) @(posedge clk_calc);
    @(negedge clk_calc);
    rst_n = 1'b1;
    fd = $fopen("tests/note_stimulus.txt", "r");
    if (fd == 0) stop_on_error("could not open tests/note_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 1 || line[0] == "#" || line[0] == "\n") continue;
      a1 = '0;
      a2 = '0;
      a3 = '0;
      rc = $sscanf(line, "%s %h %h %h", op, a1, a2, a3);
      if (op == "W") write_reg(a1[3:0], a2, a3[3:0]);
      else if (op == "R") read_reg(a1[3:0], a2);
      else if (op == "N") send_note(a1);
      else if (op == "D") expect_done(a1[7:0]);
      else if (op == "A") check_tone(a1[23:0], int'(a2), a3[0]);
      else if (op == "Z") wait_silence(int'(a1));
      else if (op == "E") check_no_done(int'(a1));
      else stop_on_error($sformatf("unknown command in stimulus file: %s", op));
    end
    $fclose(fd);
    $display("All checks passed");
    $finish;
  end

endmodule

// File: tests/note_stimulus.txt
# one command per line, all numbers hex: W addr data strb | R addr expect | N word
# D bank | A mag cycles allow_zero | Z settle_limit | E cycles (done stream stays empty)
Z 0
R 4 00000000
R 8 00000000
W 0 12345678 f
W 0 aabbccdd 5
R 0 12bb56dd
W 8 ffffffff f
R 8 00000000
R 0 12bb56dd
W 0 01000100 f
N 01000004
A 100 10 0
N 01000000
Z 5
N 00000004
N 00800004
A 200 20 1
N 00000000
N 00800000
Z 5
W 0 00000100 f
N 01000004
Z 0
R 4 00000000
W 0 01000010 f
N 00000004
W 0 01010010 f
N 01800006
N 02800002
N 00800003
D 5
D 1
D 3
E 40
R 4 00000100
N 00000000
Z 5
N 00800002
N 01000002
N 01800002
N 02000002
N 02800002
Z a
N 00800002
N 01000002
N 01800002
N 02000002
N 02800002
Z a
R 4 00000001
W 4 00000001 1
R 4 00000000
D 1
D 2
D 3
D 4
D 5
D 1
D 2
D 3
E 10

// File: sources.f
design/synth_pkg.sv
design/axil_pkg.sv
design/note_bus_if.sv
design/synth_regs.sv
design/note_decoder.sv
design/tone_bank.sv
design/voice_mixer.sv
design/done_fifo.sv
design/synth_top.sv
tests/synth_sva.sv
tests/synth_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module synth_tb \
  -f sources.f -o synth_sim > build.log 2>&1 \
  || { cat build.log; echo "build error"; exit 1; }
./obj_dir/synth_sim > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation done"
